/* all.f */
common/tomasulo_pkg.sv
source/issue_ctrl.sv
source/tagged_regs.sv
source/common_data_bus.sv
alu_unit/alu_unit.sv
mul_unit/mul_unit.sv
source/tomasulo_core.sv
dv/tb_clock.sv
dv/tb_top.sv

/* alu_unit/alu_unit.sv */
module alu_unit #(
	parameter int ALU_RS_COUNT = 4
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  issue,
	input  tomasulo_pkg::op_e     op,
	input  tomasulo_pkg::word_t   v1,
	input  tomasulo_pkg::word_t   v2,
	input  tomasulo_pkg::tag_t    q1,
	input  tomasulo_pkg::tag_t    q2,
	input  logic                  cdb_valid,
	input  tomasulo_pkg::tag_t    cdb_tag,
	input  tomasulo_pkg::word_t   cdb_data,
	input  logic                  grant,
	output logic                  all_busy,
	output tomasulo_pkg::tag_t    issue_tag,
	output logic                  cdb_req,
	output tomasulo_pkg::tag_t    res_tag,
	output tomasulo_pkg::word_t   res_data
);

	// --------------------------------------------------
	// Reservation stations
	// --------------------------------------------------
	logic [ALU_RS_COUNT-1:0] st_busy;
	logic [ALU_RS_COUNT-1:0] st_ready;              // Both operands present
	tomasulo_pkg::op_e       st_op [ALU_RS_COUNT];
	tomasulo_pkg::word_t     st_v1 [ALU_RS_COUNT];
	tomasulo_pkg::word_t     st_v2 [ALU_RS_COUNT];
	tomasulo_pkg::tag_t      st_q1 [ALU_RS_COUNT];
	tomasulo_pkg::tag_t      st_q2 [ALU_RS_COUNT];

	int                  free_idx;                  // Lowest free station
	int                  exec_idx;                  // Lowest ready station
	tomasulo_pkg::word_t a, b;
	tomasulo_pkg::word_t alu_out;

	always_comb begin : pick
		free_idx = 0;
		exec_idx = 0;
		for (int i = ALU_RS_COUNT - 1; i >= 0; i--) begin
			st_ready[i] = st_busy[i] && st_q1[i] == '0 && st_q2[i] == '0;
			if (!st_busy[i]) free_idx = i;
			if (st_ready[i]) exec_idx = i;
		end
	end

	assign all_busy  = &st_busy;
	assign issue_tag = tomasulo_pkg::make_tag(tomasulo_pkg::UNIT_ALU, free_idx);

	// --------------------------------------------------
	// Execute
	// --------------------------------------------------
	always_comb begin : execute
		a = st_v1[exec_idx];
		b = st_v2[exec_idx];
		case (st_op[exec_idx])
			tomasulo_pkg::op_add: alu_out = a + b;
			tomasulo_pkg::op_sub: alu_out = a - b;
			tomasulo_pkg::op_and: alu_out = a & b;
			tomasulo_pkg::op_or:  alu_out = a | b;
			tomasulo_pkg::op_xor: alu_out = a ^ b;
			tomasulo_pkg::op_sll: alu_out = a << b[4:0];        // Shift amount low 5 bits
			tomasulo_pkg::op_srl: alu_out = a >> b[4:0];
			tomasulo_pkg::op_slt: alu_out = tomasulo_pkg::word_t'($signed(a) < $signed(b));
			default:              alu_out = '0;                 // Mul never routed here
		endcase
	end

	assign cdb_req  = |st_ready;                // Held until granted
	assign res_tag  = tomasulo_pkg::make_tag(tomasulo_pkg::UNIT_ALU, exec_idx);
	assign res_data = alu_out;

	// --------------------------------------------------
	// Station state
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			st_busy <= '0;
		end else begin
			if (issue) st_busy[free_idx] <= 1'b1;
			if (cdb_req && grant) st_busy[exec_idx] <= 1'b0;   // Free on broadcast
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < ALU_RS_COUNT; i++) begin
			if (tomasulo_pkg::cdb_hit(cdb_valid, cdb_tag, st_q1[i])) begin
				st_v1[i] <= cdb_data;
				st_q1[i] <= '0;
			end
			if (tomasulo_pkg::cdb_hit(cdb_valid, cdb_tag, st_q2[i])) begin
				st_v2[i] <= cdb_data;
				st_q2[i] <= '0;
			end
		end
		if (issue) begin
			st_op[free_idx] <= op;
			// Snoop on the issue cycle too
			if (tomasulo_pkg::cdb_hit(cdb_valid, cdb_tag, q1)) begin
				st_v1[free_idx] <= cdb_data;
				st_q1[free_idx] <= '0;
			end else begin
				st_v1[free_idx] <= v1;
				st_q1[free_idx] <= q1;
			end
			if (tomasulo_pkg::cdb_hit(cdb_valid, cdb_tag, q2)) begin
				st_v2[free_idx] <= cdb_data;
				st_q2[free_idx] <= '0;
			end else begin
				st_v2[free_idx] <= v2;
				st_q2[free_idx] <= q2;
			end
		end
	end

endmodule

/* common/tomasulo_pkg.sv */
package tomasulo_pkg;

	// --------------------------------------------------
	// Widths and tag layout
	// --------------------------------------------------
	localparam int DATA_W     = 32;                 // Data word
	localparam int TAG_W      = 8;                  // Producer tag
	localparam int UNIT_W     = 2;                  // Unit field, top of tag
	localparam int IDX_W      = TAG_W - UNIT_W;     // Station index field
	localparam int REG_ADDR_W = 5;
	localparam int REG_COUNT  = 1 << REG_ADDR_W;    // Architectural registers

	typedef logic [DATA_W-1:0]     word_t;
	typedef logic [TAG_W-1:0]      tag_t;           // Zero means value ready
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;      // x0 never renamed

	localparam logic [UNIT_W-1:0] UNIT_ALU = 2'd1;  // Tag[7:6] for ALU stations
	localparam logic [UNIT_W-1:0] UNIT_MUL = 2'd2;  // Tag[7:6] for mul stations

	localparam int MUL_STAGES = 3;                  // Multiply latency, issue to request

	// --------------------------------------------------
	// Opcodes
	// --------------------------------------------------
	typedef enum logic [3:0] {
		op_add = 4'd0,
		op_sub = 4'd1,
		op_and = 4'd2,
		op_or  = 4'd3,
		op_xor = 4'd4,
		op_sll = 4'd5,
		op_srl = 4'd6,
		op_slt = 4'd7,   // Signed compare
		op_mul = 4'd8    // Low word of product
	} op_e;

	// Tag of station idx in a unit
	function automatic tag_t make_tag(logic [UNIT_W-1:0] unit, int idx);
		return {unit, IDX_W'(idx)};
	endfunction

	// Broadcast resolves a pending operand
	function automatic logic cdb_hit(logic valid, tag_t bus_tag, tag_t q);
		return valid && (q != '0) && (q == bus_tag);
	endfunction

endpackage

/* dv/core_stim.txt */
# I op rd rs1 rs2 imm use_imm name : issue one instruction, imm in hex
# C reg expected name : wait until reg is ready, compare value | P reg name : mul tag pending
I add  1  0  0 00000007 1 li_x1
I add  2  0  0 00000005 1 li_x2
I add  3  0  0 fffffff0 1 li_x3
I add  4  1  2 00000000 0 add_rr
I sub  5  1  2 00000000 0 sub_rr
I and  6  1  2 00000000 0 and_rr
I or   7  1  3 00000000 0 or_rr
I xor  8  1  0 0000000f 1 xor_ri
I sll  9  2  0 00000004 1 sll_ri
I srl 12  3  2 00000000 0 srl_rr
I slt 13  3  1 00000000 0 slt_rr
I slt 14  3  0 00000000 1 slt_ri
C  4 0000000c add_rr
C  5 00000002 sub_rr
C  6 00000005 and_rr
C  7 fffffff7 or_rr
C  8 00000008 xor_ri
C  9 00000050 sll_ri
C 12 07ffffff srl_rr
C 13 00000001 slt_rr
C 14 00000001 slt_ri
# RAW chain through a mul
I mul 15  1  2 00000000 0 raw_mul
I add 16 15  0 00000001 1 raw_add
I sub 17 16  1 00000000 0 raw_sub
I mul 19  1  3 00000000 0 pend_src
I mul 20 19  2 00000000 0 pend_dep
P 20 pend_tag
C 15 00000023 raw_mul
C 16 00000024 raw_add
C 17 0000001d raw_sub
C 19 ffffff90 pend_src
C 20 fffffdd0 pend_dep
# WAW, slow mul then fast add to the same rd, and x0 targeted
I mul 21  1  1 00000000 0 waw_mul
I add 21  2  0 00000100 1 waw_add
I mul  0  1  2 00000000 0 x0_mul
I add  0  1  0 00000005 1 x0_add
C 21 00000105 waw_final
C  0 00000000 x0_zero
# Back-pressure on the mul stations
I mul 22  1  1 00000000 0 bp_0
I mul 23  2  2 00000000 0 bp_1
I mul 24  1  2 00000000 0 bp_2
I mul 25  3  2 00000000 0 bp_3
I mul 26 22  2 00000000 0 bp_4
I mul 27 26  1 00000000 0 bp_5
I mul 28  3  3 00000000 0 bp_6
C 22 00000031 bp_0
C 23 00000019 bp_1
C 24 00000023 bp_2
C 25 ffffffb0 bp_3
C 26 000000f5 bp_4
C 27 000006b3 bp_5
C 28 00000100 bp_6

/* dv/tb_clock.sv */
module tb_clock (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;     // Period 20
	end

	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst <= 1'b0;                // Released on the falling edge after two rising edges
	end

endmodule

/* dv/tb_top.sv */
module tb_top;

	typedef logic [8*24-1:0] name_t;                // Test name from the stim file

	localparam int MAX_LINES = 128;

	logic                    clk, rst;
	logic                    req, ack, use_imm;
	tomasulo_pkg::op_e       op;
	tomasulo_pkg::reg_addr_t rd, rs1, rs2, obs_addr;
	tomasulo_pkg::word_t     imm, obs_data;
	tomasulo_pkg::tag_t      obs_tag;

	// Parsed stimulus, one entry per non-comment line
	logic [7:0]              s_kind    [MAX_LINES]; // I, C or P
	tomasulo_pkg::op_e       s_op      [MAX_LINES];
	tomasulo_pkg::reg_addr_t s_rd      [MAX_LINES]; // rd, or register to read
	tomasulo_pkg::reg_addr_t s_rs1     [MAX_LINES];
	tomasulo_pkg::reg_addr_t s_rs2     [MAX_LINES];
	tomasulo_pkg::word_t     s_imm     [MAX_LINES]; // imm, or expected value
	logic                    s_use_imm [MAX_LINES];
	name_t                   s_name    [MAX_LINES];
	int                      n_lines;
	logic                    stim_loaded;

	int          checks, value_errors, tag_errors, proto_errors;
	logic [31:0] lcg_state;

	tb_clock u_clock (.clk(clk), .rst(rst));

	tomasulo_core #(.ALU_RS_COUNT(4), .MUL_RS_COUNT(2)) dut (
		.clk(clk), .rst(rst), .req(req), .op(op),
		.rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm), .use_imm(use_imm),
		.ack(ack), .obs_addr(obs_addr), .obs_data(obs_data), .obs_tag(obs_tag)
	);

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic tomasulo_pkg::op_e op_from_name(input logic [63:0] s, output logic known);
		known = 1'b1;
		case (s)
			64'("add"): return tomasulo_pkg::op_add;
			64'("sub"): return tomasulo_pkg::op_sub;
			64'("and"): return tomasulo_pkg::op_and;
			64'("or"):  return tomasulo_pkg::op_or;
			64'("xor"): return tomasulo_pkg::op_xor;
			64'("sll"): return tomasulo_pkg::op_sll;
			64'("srl"): return tomasulo_pkg::op_srl;
			64'("slt"): return tomasulo_pkg::op_slt;
			64'("mul"): return tomasulo_pkg::op_mul;
			default: begin
				known = 1'b0;
				return tomasulo_pkg::op_add;
			end
		endcase
	endfunction

	task automatic check_word(input name_t name, input tomasulo_pkg::word_t expected,
			input tomasulo_pkg::word_t actual);
		checks++;
		if (actual !== expected) begin
			value_errors++;
			$display("** Error: %0s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_tag(input name_t name, input tomasulo_pkg::tag_t expected,
			input tomasulo_pkg::tag_t actual);
		checks++;
		if (actual !== expected) begin
			tag_errors++;
			$display("** Error: %0s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// --------------------------------------------------
	// Stimulus file
	// --------------------------------------------------
	task automatic load_stim();
		int               fd;
		int               code;
		int               a, b, c, u;
		logic [8*128-1:0] line;
		logic [63:0]      kind, opname;
		tomasulo_pkg::word_t w;
		name_t            name;
		logic             known;
		fd = $fopen("dv/core_stim.txt", "r");
		if (fd == 0) begin
			proto_errors++;
			$display("Stimulus file dv/core_stim.txt could not be opened");
			return;
		end
		while (!$feof(fd) && n_lines < MAX_LINES) begin
			line = '0;
			kind = '0;
			code = $fgets(line, fd);
			code = $sscanf(line, "%s", kind);
			if (code < 1 || kind == 64'("#")) continue;  // Blank or comment
			s_kind[n_lines] = kind[7:0];
			case (kind)
				64'("I"): begin
					code = $sscanf(line, "%s %s %d %d %d %h %d %s",
						kind, opname, a, b, c, w, u, name);
					s_op[n_lines] = op_from_name(opname, known);
					if (code != 8 || !known) begin
						proto_errors++;
						$display("Stimulus line %0d has a bad issue entry", n_lines);
						continue;
					end
					s_rs1[n_lines]     = tomasulo_pkg::reg_addr_t'(b);
					s_rs2[n_lines]     = tomasulo_pkg::reg_addr_t'(c);
					s_use_imm[n_lines] = (u != 0);
				end
				64'("C"): code = $sscanf(line, "%s %d %h %s", kind, a, w, name) - 4;
				64'("P"): code = $sscanf(line, "%s %d %s", kind, a, name) - 3;
				default:  code = -1;                     // Unknown line kind
			endcase
			if (code < 0) begin
				proto_errors++;
				$display("Stimulus line %0d could not be parsed", n_lines);
				continue;
			end
			s_rd[n_lines]   = tomasulo_pkg::reg_addr_t'(a);
			s_imm[n_lines]  = w;
			s_name[n_lines] = name;
			n_lines++;
		end
		$fclose(fd);
	endtask

	// --------------------------------------------------
	// Drivers, all entered and left on a falling edge
	// --------------------------------------------------
	task automatic issue(input int i);
		if (ack !== 1'b0) begin
			proto_errors++;
			$display("Handshake overlap: ack still high when req rises for %0s", s_name[i]);
		end
		op      = s_op[i];
		rd      = s_rd[i];
		rs1     = s_rs1[i];
		rs2     = s_rs2[i];
		imm     = s_imm[i];
		use_imm = s_use_imm[i];
		req     = 1'b1;
		@(negedge clk);
		while (ack !== 1'b1) @(negedge clk);        // Back-pressure stretches this
		req = 1'b0;
		@(negedge clk);
		while (ack !== 1'b0) @(negedge clk);
	endtask

	task automatic check_reg(input int i);
		obs_addr = s_rd[i];
		@(negedge clk);
		while (obs_tag !== '0) @(negedge clk);      // Result still in flight
		check_word(s_name[i], s_imm[i], obs_data);
	endtask

	// Mul just issued, its rd names a mul station
	task automatic check_pending(input int i);
		obs_addr = s_rd[i];
		@(negedge clk);
		check_tag(s_name[i], tomasulo_pkg::tag_t'(tomasulo_pkg::UNIT_MUL),
			tomasulo_pkg::tag_t'(obs_tag >> tomasulo_pkg::IDX_W));
	endtask

	task automatic check_reset();
		if (ack !== 1'b0) begin
			proto_errors++;
			$display("ack is high after reset");
		end
		for (int r = 0; r < tomasulo_pkg::REG_COUNT; r++) begin
			obs_addr = tomasulo_pkg::reg_addr_t'(r);
			@(negedge clk);
			check_word(name_t'("reset_value"), '0, obs_data);
			check_tag(name_t'("reset_tag"), '0, obs_tag);
		end
	endtask

	// --------------------------------------------------
	// Main sequence and watchdog
	// --------------------------------------------------
	initial begin : main
		req         = 1'b0;
		op          = tomasulo_pkg::op_add;
		rd          = '0;
		rs1         = '0;
		rs2         = '0;
		imm         = '0;
		use_imm     = 1'b0;
		obs_addr    = '0;
		stim_loaded = 1'b0;
		n_lines     = 0;
		checks      = 0;
		value_errors = 0;
		tag_errors  = 0;
		proto_errors = 0;
		lcg_state   = 32'h57a;
		load_stim();
		stim_loaded = 1'b1;
		@(negedge clk);
		while (rst) @(negedge clk);
		check_reset();
		for (int i = 0; i < n_lines; i++) begin
			if (s_kind[i] == 8'("I")) begin
				lcg_state = lcg_next(lcg_state);
				repeat (int'(lcg_state[17:16])) @(negedge clk);  // 0 to 3 idle cycles
				issue(i);
			end else if (s_kind[i] == 8'("C")) begin
				check_reg(i);
			end else begin
				check_pending(i);
			end
		end
		$display("Checks %0d, value errors %0d, tag errors %0d, protocol errors %0d",
			checks, value_errors, tag_errors, proto_errors);
		if (value_errors + tag_errors + proto_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		wait (stim_loaded === 1'b1);
		repeat ((n_lines + 10) * 40) @(posedge clk);
		$display("Run timed out after %0d cycles", (n_lines + 10) * 40);
		$display(">>> FAIL");
		$finish;
	end

endmodule

/* mul_unit/mul_unit.sv */
module mul_unit #(
	parameter int MUL_RS_COUNT = 2
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  issue,
	input  tomasulo_pkg::word_t   v1,
	input  tomasulo_pkg::word_t   v2,
	input  tomasulo_pkg::tag_t    q1,
	input  tomasulo_pkg::tag_t    q2,
	input  logic                  cdb_valid,
	input  tomasulo_pkg::tag_t    cdb_tag,
	input  tomasulo_pkg::word_t   cdb_data,
	output logic                  all_busy,
	output tomasulo_pkg::tag_t    issue_tag,
	output logic                  cdb_req,
	output tomasulo_pkg::tag_t    res_tag,
	output tomasulo_pkg::word_t   res_data
);

	localparam int STG = tomasulo_pkg::MUL_STAGES;

	logic [MUL_RS_COUNT-1:0] st_busy;
	logic [MUL_RS_COUNT-1:0] st_ready;
	logic [MUL_RS_COUNT-1:0] st_inflight;           // Tag still in the pipeline
	tomasulo_pkg::word_t     st_v1 [MUL_RS_COUNT];
	tomasulo_pkg::word_t     st_v2 [MUL_RS_COUNT];
	tomasulo_pkg::tag_t      st_q1 [MUL_RS_COUNT];
	tomasulo_pkg::tag_t      st_q2 [MUL_RS_COUNT];

	logic [STG-1:0]      pipe_v;
	tomasulo_pkg::tag_t  pipe_tag [STG];
	tomasulo_pkg::word_t mul_a, mul_b;              // Stage 1 operands
	tomasulo_pkg::word_t prod [STG-1];              // Stage 2 onward

	int   free_idx;
	int   exec_idx;
	logic launch;

	// --------------------------------------------------
	// Station select
	// --------------------------------------------------
	always_comb begin : pick
		free_idx = 0;
		exec_idx = 0;
		for (int i = MUL_RS_COUNT - 1; i >= 0; i--) begin
			st_inflight[i] = 1'b0;
			for (int s = 0; s < STG; s++) begin
				if (pipe_v[s] && pipe_tag[s] == tomasulo_pkg::make_tag(tomasulo_pkg::UNIT_MUL, i))
					st_inflight[i] = 1'b1;
			end
			st_ready[i] = st_busy[i] && st_q1[i] == '0 && st_q2[i] == '0;
			if (!st_busy[i] && !st_inflight[i]) free_idx = i;   // Tag reused only after broadcast
			if (st_ready[i]) exec_idx = i;
		end
	end

	assign all_busy  = &(st_busy | st_inflight);
	assign issue_tag = tomasulo_pkg::make_tag(tomasulo_pkg::UNIT_MUL, free_idx);
	assign launch    = |st_ready;                   // Stage 1 frees every cycle

	// --------------------------------------------------
	// Product pipeline, never stalls
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			pipe_v  <= '0;
			st_busy <= '0;
		end else begin
			pipe_v <= {pipe_v[STG-2:0], launch};
			if (issue) st_busy[free_idx] <= 1'b1;
			if (launch) st_busy[exec_idx] <= 1'b0;   // Free at launch
		end
	end

	always_ff @(posedge clk) begin
		pipe_tag[0] <= tomasulo_pkg::make_tag(tomasulo_pkg::UNIT_MUL, exec_idx);
		mul_a       <= st_v1[exec_idx];
		mul_b       <= st_v2[exec_idx];
		prod[0]     <= mul_a * mul_b;               // Low word only
		for (int s = 1; s < STG; s++) pipe_tag[s] <= pipe_tag[s-1];
		for (int s = 1; s < STG - 1; s++) prod[s] <= prod[s-1];
	end

	assign cdb_req  = pipe_v[STG-1];                // Always granted
	assign res_tag  = pipe_tag[STG-1];
	assign res_data = prod[STG-2];

	// --------------------------------------------------
	// Operand capture
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		for (int i = 0; i < MUL_RS_COUNT; i++) begin
			if (tomasulo_pkg::cdb_hit(cdb_valid, cdb_tag, st_q1[i])) begin
				st_v1[i] <= cdb_data;
				st_q1[i] <= '0;
			end
			if (tomasulo_pkg::cdb_hit(cdb_valid, cdb_tag, st_q2[i])) begin
				st_v2[i] <= cdb_data;
				st_q2[i] <= '0;
			end
		end
		if (issue) begin
			st_v1[free_idx] <= tomasulo_pkg::cdb_hit(cdb_valid, cdb_tag, q1) ? cdb_data : v1;
			st_q1[free_idx] <= tomasulo_pkg::cdb_hit(cdb_valid, cdb_tag, q1) ? '0 : q1;
			st_v2[free_idx] <= tomasulo_pkg::cdb_hit(cdb_valid, cdb_tag, q2) ? cdb_data : v2;
			st_q2[free_idx] <= tomasulo_pkg::cdb_hit(cdb_valid, cdb_tag, q2) ? '0 : q2;
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# Build the core testbench with Verilator, run it, and pass only on the pass line
cd "$(dirname "$0")" \
	&& verilator --binary --timing -Wno-fatal --top-module tb_top -f all.f -Mdir obj_dir \
	&& ./obj_dir/Vtb_top | tee /dev/stderr | grep -qx '>>> PASS' \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* source/common_data_bus.sv */
module common_data_bus (
	input  logic                  alu_req,
	input  logic                  mul_req,
	input  tomasulo_pkg::tag_t    alu_tag,
	input  tomasulo_pkg::tag_t    mul_tag,
	input  tomasulo_pkg::word_t   alu_data,
	input  tomasulo_pkg::word_t   mul_data,
	output logic                  alu_grant,
	output logic                  cdb_valid,
	output tomasulo_pkg::tag_t    cdb_tag,
	output tomasulo_pkg::word_t   cdb_data
);

	// --------------------------------------------------
	// Fixed priority, mul pipeline cannot wait
	// --------------------------------------------------
	assign alu_grant = alu_req & ~mul_req;           // ALU holds its request otherwise
	assign cdb_valid = alu_req | mul_req;
	assign cdb_tag   = mul_req ? mul_tag : alu_tag;
	assign cdb_data  = mul_req ? mul_data : alu_data;

endmodule

/* source/issue_ctrl.sv */
module issue_ctrl (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  req,
	input  tomasulo_pkg::op_e     op,
	input  logic                  use_imm,
	input  tomasulo_pkg::word_t   imm,
	input  tomasulo_pkg::word_t   rs2_val,
	input  tomasulo_pkg::tag_t    rs2_tag,
	input  logic                  alu_busy,
	input  logic                  mul_busy,
	input  tomasulo_pkg::tag_t    alu_tag,     // Next free ALU station
	input  tomasulo_pkg::tag_t    mul_tag,     // Next free mul station
	output logic                  ack,
	output logic                  alu_issue,
	output logic                  mul_issue,
	output logic                  rename_en,
	output tomasulo_pkg::tag_t    rename_tag,
	output tomasulo_pkg::word_t   opb_val,
	output tomasulo_pkg::tag_t    opb_tag
);

	logic to_mul;      // Instruction targets the multiplier
	logic unit_busy;   // Target unit full
	logic fire;        // Issue this cycle

	// --------------------------------------------------
	// Dispatch and rename
	// --------------------------------------------------
	assign to_mul    = (op == tomasulo_pkg::op_mul);
	assign unit_busy = to_mul ? mul_busy : alu_busy;    // Structural hazard
	assign fire      = req & ~ack & ~unit_busy;         // New request, room in unit

	assign alu_issue  = fire & ~to_mul;
	assign mul_issue  = fire & to_mul;
	assign rename_en  = fire;                           // Same cycle as the issue pulse
	assign rename_tag = to_mul ? mul_tag : alu_tag;

	// Immediate operand is always ready
	assign opb_val = use_imm ? imm : rs2_val;
	assign opb_tag = use_imm ? '0 : rs2_tag;

	// --------------------------------------------------
	// Four-phase handshake
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			ack <= 1'b0;
		end else if (fire) begin
			ack <= 1'b1;        // Accepted, held until req drops
		end else if (!req) begin
			ack <= 1'b0;        // Back to idle
		end
	end

endmodule

/* source/tagged_regs.sv */
module tagged_regs (
	input  logic                      clk,
	input  logic                      rst,
	input  tomasulo_pkg::reg_addr_t   rs1,
	input  tomasulo_pkg::reg_addr_t   rs2,
	input  tomasulo_pkg::reg_addr_t   rd,
	input  tomasulo_pkg::reg_addr_t   obs_addr,
	input  logic                      rename_en,
	input  tomasulo_pkg::tag_t        rename_tag,
	input  logic                      cdb_valid,
	input  tomasulo_pkg::tag_t        cdb_tag,
	input  tomasulo_pkg::word_t       cdb_data,
	output tomasulo_pkg::word_t       rs1_val,
	output tomasulo_pkg::word_t       rs2_val,
	output tomasulo_pkg::tag_t        rs1_tag,
	output tomasulo_pkg::tag_t        rs2_tag,
	output tomasulo_pkg::word_t       obs_data,
	output tomasulo_pkg::tag_t        obs_tag
);

	tomasulo_pkg::word_t reg_val [tomasulo_pkg::REG_COUNT];
	tomasulo_pkg::tag_t  reg_tag [tomasulo_pkg::REG_COUNT];    // Pending producer

	logic rs1_hit, rs2_hit, obs_hit;   // Resolved by this cycle's broadcast

	// --------------------------------------------------
	// Read ports with broadcast bypass
	// --------------------------------------------------
	assign rs1_hit = tomasulo_pkg::cdb_hit(cdb_valid, cdb_tag, reg_tag[rs1]);
	assign rs2_hit = tomasulo_pkg::cdb_hit(cdb_valid, cdb_tag, reg_tag[rs2]);
	assign obs_hit = tomasulo_pkg::cdb_hit(cdb_valid, cdb_tag, reg_tag[obs_addr]);

	assign rs1_val  = rs1_hit ? cdb_data : reg_val[rs1];
	assign rs1_tag  = rs1_hit ? '0 : reg_tag[rs1];
	assign rs2_val  = rs2_hit ? cdb_data : reg_val[rs2];
	assign rs2_tag  = rs2_hit ? '0 : reg_tag[rs2];
	assign obs_data = obs_hit ? cdb_data : reg_val[obs_addr];
	assign obs_tag  = obs_hit ? '0 : reg_tag[obs_addr];

	// --------------------------------------------------
	// Capture and rename
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < tomasulo_pkg::REG_COUNT; i++) begin
				reg_val[i] <= '0;
				reg_tag[i] <= '0;
			end
		end else begin
			// x0 skipped, never pending
			for (int i = 1; i < tomasulo_pkg::REG_COUNT; i++) begin
				if (tomasulo_pkg::cdb_hit(cdb_valid, cdb_tag, reg_tag[i])) begin
					reg_val[i] <= cdb_data;   // Only the latest producer matches
					reg_tag[i] <= '0;
				end
			end
			if (rename_en && rd != '0) begin
				reg_tag[rd] <= rename_tag;    // Overrides a same-cycle capture
			end
		end
	end

endmodule

/* source/tomasulo_core.sv */
module tomasulo_core #(
	parameter int ALU_RS_COUNT = 4,
	parameter int MUL_RS_COUNT = 2
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      req,        // Four-phase request
	input  tomasulo_pkg::op_e         op,
	input  tomasulo_pkg::reg_addr_t   rd,
	input  tomasulo_pkg::reg_addr_t   rs1,
	input  tomasulo_pkg::reg_addr_t   rs2,
	input  tomasulo_pkg::word_t       imm,
	input  logic                      use_imm,    // Immediate replaces rs2
	output logic                      ack,
	input  tomasulo_pkg::reg_addr_t   obs_addr,   // Observation port
	output tomasulo_pkg::word_t       obs_data,
	output tomasulo_pkg::tag_t        obs_tag
);

	// --------------------------------------------------
	// Issue path
	// --------------------------------------------------
	tomasulo_pkg::word_t rs1_val, rs2_val, opb_val;
	tomasulo_pkg::tag_t  rs1_tag, rs2_tag, opb_tag;
	tomasulo_pkg::tag_t  rename_tag;
	logic                rename_en;
	logic                alu_issue, mul_issue;
	logic                alu_busy, mul_busy;         // No free station
	tomasulo_pkg::tag_t  alu_issue_tag, mul_issue_tag;

	// --------------------------------------------------
	// Result path
	// --------------------------------------------------
	logic                alu_cdb_req, mul_cdb_req;
	tomasulo_pkg::tag_t  alu_res_tag, mul_res_tag;
	tomasulo_pkg::word_t alu_res_data, mul_res_data;
	logic                alu_grant;
	logic                cdb_valid;
	tomasulo_pkg::tag_t  cdb_tag;
	tomasulo_pkg::word_t cdb_data;

	issue_ctrl u_issue (
		.clk(clk), .rst(rst), .req(req), .op(op),
		.use_imm(use_imm), .imm(imm),
		.rs2_val(rs2_val), .rs2_tag(rs2_tag),
		.alu_busy(alu_busy), .mul_busy(mul_busy),
		.alu_tag(alu_issue_tag), .mul_tag(mul_issue_tag),
		.ack(ack), .alu_issue(alu_issue), .mul_issue(mul_issue),
		.rename_en(rename_en), .rename_tag(rename_tag),
		.opb_val(opb_val), .opb_tag(opb_tag)
	);

	tagged_regs u_regs (
		.clk(clk), .rst(rst),
		.rs1(rs1), .rs2(rs2), .rd(rd), .obs_addr(obs_addr),
		.rename_en(rename_en), .rename_tag(rename_tag),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
		.rs1_val(rs1_val), .rs2_val(rs2_val),
		.rs1_tag(rs1_tag), .rs2_tag(rs2_tag),
		.obs_data(obs_data), .obs_tag(obs_tag)
	);

	alu_unit #(.ALU_RS_COUNT(ALU_RS_COUNT)) u_alu (
		.clk(clk), .rst(rst), .issue(alu_issue), .op(op),
		.v1(rs1_val), .v2(opb_val), .q1(rs1_tag), .q2(opb_tag),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
		.grant(alu_grant),
		.all_busy(alu_busy), .issue_tag(alu_issue_tag),
		.cdb_req(alu_cdb_req), .res_tag(alu_res_tag), .res_data(alu_res_data)
	);

	mul_unit #(.MUL_RS_COUNT(MUL_RS_COUNT)) u_mul (
		.clk(clk), .rst(rst), .issue(mul_issue),
		.v1(rs1_val), .v2(opb_val), .q1(rs1_tag), .q2(opb_tag),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
		.all_busy(mul_busy), .issue_tag(mul_issue_tag),
		.cdb_req(mul_cdb_req), .res_tag(mul_res_tag), .res_data(mul_res_data)
	);

	common_data_bus u_cdb (
		.alu_req(alu_cdb_req), .mul_req(mul_cdb_req),
		.alu_tag(alu_res_tag), .mul_tag(mul_res_tag),
		.alu_data(alu_res_data), .mul_data(mul_res_data),
		.alu_grant(alu_grant),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data)
	);

endmodule
